// File: tb.f
rtl/vip_pkg.sv
rtl/pw_entry_if.sv
rtl/password_unit.sv
rtl/vip_menu_fsm.sv
rtl/bin_to_bcd.sv
rtl/vip_display.sv
rtl/vip_check_top.sv
tb/tb_vip_check.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the kiosk member screen testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_vip_check \
    -f tb.f -o sim_vip > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_vip > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: tb/tb_vip_check.sv
`timescale 1ns/1ps

module tb_vip_check;

    localparam int AMOUNT_W = 14;
    localparam int DIGITS   = 4;
    localparam int LIMIT    = 200; // cycles allowed per wait
    localparam int SW       = vip_pkg::SHOW_W;

    localparam logic [SW-1:0] BLANKS  = {6{vip_pkg::GLYPH_BLANK}};
    localparam logic [SW-1:0] PROMPT  = {vip_pkg::GLYPH_P, {5{vip_pkg::GLYPH_BLANK}}};
    localparam logic [SW-1:0] PROMPT2 = {vip_pkg::GLYPH_R, vip_pkg::GLYPH_P,
                                         {4{vip_pkg::GLYPH_BLANK}}};
    localparam logic [SW-1:0] MENU    = {vip_pkg::GLYPH_U, vip_pkg::GLYPH_BLANK, vip_pkg::GLYPH_D,
                                         vip_pkg::GLYPH_O, vip_pkg::GLYPH_BLANK,
                                         vip_pkg::GLYPH_QUERY};
    localparam logic [SW-1:0] ERROR   = {vip_pkg::GLYPH_BLANK, vip_pkg::GLYPH_E, vip_pkg::GLYPH_R,
                                         vip_pkg::GLYPH_R, vip_pkg::GLYPH_O, vip_pkg::GLYPH_R};
    localparam logic [SW-1:0] NOVIP   = {vip_pkg::GLYPH_N, vip_pkg::GLYPH_O, vip_pkg::GLYPH_BLANK,
                                         vip_pkg::GLYPH_V, vip_pkg::GLYPH_I, vip_pkg::GLYPH_P};
    localparam logic [SW-1:0] CANCEL  = {vip_pkg::GLYPH_C, vip_pkg::GLYPH_A, vip_pkg::GLYPH_N,
                                         vip_pkg::GLYPH_C, vip_pkg::GLYPH_E, vip_pkg::GLYPH_L};
    localparam logic [SW-1:0] SIXES   = {6{vip_pkg::GLYPH_SIX}};

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     en_i;
    vip_pkg::btn_t            press_i;
    logic [7:0]               switch_i;
    logic [1:0]               member_i;
    logic [vip_pkg::PW_W-1:0] stored_pw_i;
    logic [AMOUNT_W-1:0]      cost_i;
    logic [AMOUNT_W-1:0]      save_i;
    logic                     entry_done_i;
    logic [vip_pkg::PW_W-1:0] entry_word_i;
    logic                     entry_req_o;
    logic [SW-1:0]            show_o;
    logic                     wr_o;
    vip_pkg::wr_kind_t        wr_kind_o;
    logic [vip_pkg::PW_W-1:0] new_pw_o;
    logic                     exit_o;

    logic [SW-1:0]            exp_show;
    logic [SW-1:0]            exp_prompt; // expected when entry_req_o rises
    vip_pkg::wr_kind_t        exp_kind;
    logic [vip_pkg::PW_W-1:0] exp_new_pw;
    logic                     wr_ok;
    logic                     exit_ok;
    logic                     press_due;
    logic                     en_q  = 1'b0;
    logic                     req_q = 1'b0;
    logic [2:0]               due_q = '0; // show check lands at the tail
    logic [vip_pkg::PW_W-1:0] word_q[$];
    logic [7:0]               lfsr;
    int show_err   = 0;
    int strobe_err = 0;
    int wait_err   = 0;
    int wr_cnt     = 0;
    int exit_cnt   = 0;
    int req_cnt    = 0;

    vip_check_top #(.AMOUNT_W(AMOUNT_W), .DIGITS(DIGITS)) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .en_i         (en_i),
        .press_i      (press_i),
        .switch_i     (switch_i),
        .member_i     (member_i),
        .stored_pw_i  (stored_pw_i),
        .cost_i       (cost_i),
        .save_i       (save_i),
        .entry_done_i (entry_done_i),
        .entry_word_i (entry_word_i),
        .entry_req_o  (entry_req_o),
        .show_o       (show_o),
        .wr_o         (wr_o),
        .wr_kind_o    (wr_kind_o),
        .new_pw_o     (new_pw_o),
        .exit_o       (exit_o)
    );

    always #10 clk = ~clk;

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    // decimal digits by division, saturating at all nines
    function automatic logic [DIGITS*vip_pkg::GLYPH_W-1:0] amount_glyphs(input int value);
        logic [DIGITS*vip_pkg::GLYPH_W-1:0] g;
        int v;
        g = '0;
        v = (value > 10**DIGITS - 1) ? 10**DIGITS - 1 : value;
        for (int d = 0; d < DIGITS; d++)
            g[d*vip_pkg::GLYPH_W +: vip_pkg::GLYPH_W] = 5'((v / (10**d)) % 10);
        return g;
    endfunction

    always @(posedge clk) begin
        en_q     <= en_i;
        req_q    <= entry_req_o;
        due_q[0] <= entry_done_i;
        due_q[1] <= due_q[0] | press_due | (en_i & ~en_q);
        due_q[2] <= due_q[1];
        if (wr_o) wr_cnt <= wr_cnt + 1;
        if (exit_o) exit_cnt <= exit_cnt + 1;
        if (entry_req_o && !req_q) req_cnt <= req_cnt + 1;
    end

    a_show: assert property (@(posedge clk) disable iff (!rst_n) due_q[2] |-> show_o == exp_show)
        else begin
            show_err++;
            $display("** Error at %0t: show_o = %h, expected %h", $time, $sampled(show_o),
                     exp_show);
        end
    a_prompt: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(entry_req_o) |-> show_o == exp_prompt)
        else begin
            show_err++;
            $display("** Error at %0t: show_o = %h, expected %h", $time, $sampled(show_o),
                     exp_prompt);
        end
    a_off: assert property (@(posedge clk) disable iff (!rst_n)
        !en_i |=> show_o == BLANKS && !entry_req_o && !wr_o && !exit_o)
        else begin
            show_err++;
            $display("** Error at %0t: show_o = %h, expected %h; req/wr/exit = %b%b%b, expected 000",
                     $time, $sampled(show_o), BLANKS, $sampled(entry_req_o), $sampled(wr_o),
                     $sampled(exit_o));
        end
    a_wr_ok: assert property (@(posedge clk) disable iff (!rst_n) wr_o |-> wr_ok)
        else begin
            strobe_err++;
            $display("unexpected wr_o pulse at %0t", $time);
        end
    a_wr_kind: assert property (@(posedge clk) disable iff (!rst_n) wr_o |-> wr_kind_o == exp_kind)
        else begin
            strobe_err++;
            $display("** Error at %0t: wr_kind_o = %0d, expected %0d", $time,
                     $sampled(wr_kind_o), exp_kind);
        end
    a_new_pw: assert property (@(posedge clk) disable iff (!rst_n)
        wr_o && wr_kind_o == vip_pkg::WR_UPDATE |-> new_pw_o == exp_new_pw)
        else begin
            strobe_err++;
            $display("** Error at %0t: new_pw_o = %h, expected %h", $time, $sampled(new_pw_o),
                     exp_new_pw);
        end
    a_exit: assert property (@(posedge clk) disable iff (!rst_n) exit_o |-> exit_ok)
        else begin
            strobe_err++;
            $display("unexpected exit_o pulse at %0t", $time);
        end

    // keypad reader, answers after 1 to 8 cycles
    initial begin : keypad
        int delay;
        entry_done_i = 1'b0;
        entry_word_i = '0;
        lfsr         = 8'd18;
        forever begin
            @(negedge clk);
            if (entry_req_o && word_q.size() > 0) begin
                delay = 1;
                for (int b = 0; b < 3; b++) begin
                    delay = delay + (int'(lfsr[0]) << b);
                    lfsr  = lfsr_next(lfsr);
                end
                repeat (delay) @(posedge clk);
                #2;
                entry_word_i = word_q.pop_front();
                entry_done_i = 1'b1;
                @(posedge clk);
                #2;
                entry_done_i = 1'b0;
            end
        end
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic push(input vip_pkg::btn_t btn, input logic [SW-1:0] show);
        press_i   = btn;
        exp_show  = show;
        press_due = 1'b1;
        tick(1);
        press_i   = vip_pkg::BTN_NONE;
        press_due = 1'b0;
        tick(3);
    endtask

    task automatic wait_req();
        int n;
        for (n = 0; n < LIMIT && !entry_req_o; n++) @(negedge clk);
        if (!entry_req_o) begin
            wait_err++;
            $display("timeout at %0t: entry_req_o never rose", $time);
        end
        tick(1);
    endtask

    task automatic enter_word(input logic [vip_pkg::PW_W-1:0] word, input logic [SW-1:0] show);
        int n;
        exp_show = show;
        word_q.push_back(word);
        for (n = 0; n < LIMIT && !entry_done_i; n++) @(negedge clk);
        if (!entry_done_i) begin
            wait_err++;
            $display("timeout at %0t: keypad never answered", $time);
        end
        tick(4); // done to display takes three edges
    endtask

    task automatic check_count(input string name, input int got, input int want);
        assert (got == want) else begin
            strobe_err++;
            $display("** Error at %0t: %s count = %0d, expected %0d", $time, name, got, want);
        end
    endtask

    initial begin : stimulus
        int rises;
        rst_n       = 1'b0;
        en_i        = 1'b0;
        press_i     = vip_pkg::BTN_NONE;
        switch_i    = '0;
        member_i    = 2'b00;
        stored_pw_i = 20'h1a2b3;
        cost_i      = AMOUNT_W'(1234);
        save_i      = AMOUNT_W'(12000); // beyond four digits
        exp_show    = BLANKS;
        exp_prompt  = PROMPT;
        exp_kind    = vip_pkg::WR_UPDATE;
        exp_new_pw  = '0;
        wr_ok       = 1'b0;
        exit_ok     = 1'b0;
        press_due   = 1'b0;
        tick(10);
        rst_n = 1'b1;
        tick(3);

        // non-member
        exp_show = NOVIP;
        en_i     = 1'b1;
        tick(3);
        exit_ok = 1'b1;
        push(vip_pkg::BTN_CONFIRM, BLANKS);
        exit_ok = 1'b0;
        check_count("exit_o", exit_cnt, 1);
        en_i = 1'b0;
        tick(3);

        // login, wrong then right
        member_i = vip_pkg::MEMBER_ACTIVE;
        exp_show = PROMPT;
        en_i     = 1'b1;
        wait_req();
        enter_word(stored_pw_i ^ 20'h00001, ERROR);
        push(vip_pkg::BTN_CONFIRM, PROMPT);
        wait_req();
        enter_word(stored_pw_i, MENU);

        switch_i = vip_pkg::MENU_COST;
        push(vip_pkg::BTN_CONFIRM, {vip_pkg::GLYPH_C, vip_pkg::GLYPH_O,
                                    amount_glyphs(int'(cost_i))});
        push(vip_pkg::BTN_BACK, MENU);
        switch_i = vip_pkg::MENU_SAVE;
        push(vip_pkg::BTN_CONFIRM, {5'd5, vip_pkg::GLYPH_A, amount_glyphs(int'(save_i))});
        push(vip_pkg::BTN_BACK, MENU);

        // password change, matching entries
        switch_i = vip_pkg::MENU_PW;
        push(vip_pkg::BTN_CONFIRM, PROMPT);
        wait_req();
        exp_prompt = PROMPT2;
        exp_new_pw = 20'h0c3e1;
        exp_kind   = vip_pkg::WR_UPDATE;
        wr_ok      = 1'b1;
        enter_word(20'h0c3e1, PROMPT2);
        wait_req();
        enter_word(20'h0c3e1, SIXES);
        tick(2);
        wr_ok = 1'b0;
        check_count("wr_o", wr_cnt, 1);
        push(vip_pkg::BTN_CONFIRM, MENU);

        // mismatch
        exp_prompt = PROMPT;
        push(vip_pkg::BTN_CONFIRM, PROMPT);
        wait_req();
        exp_prompt = PROMPT2;
        enter_word(20'h11111, PROMPT2);
        wait_req();
        enter_word(20'h22222, ERROR);
        tick(2);
        check_count("wr_o", wr_cnt, 1);

        // HOME while the second entry is pending
        push(vip_pkg::BTN_BACK, PROMPT2);
        wait_req();
        exp_prompt = PROMPT;
        rises      = req_cnt;
        push(vip_pkg::BTN_HOME, BLANKS);
        wait_req();
        check_count("entry_req_o rise", req_cnt, rises + 1);
        enter_word(stored_pw_i, MENU);

        // cancellation
        switch_i = vip_pkg::MENU_CANCEL;
        push(vip_pkg::BTN_CONFIRM, CANCEL);
        exp_kind = vip_pkg::WR_CANCEL;
        wr_ok    = 1'b1;
        push(vip_pkg::BTN_CONFIRM, SIXES);
        wr_ok = 1'b0;
        check_count("wr_o", wr_cnt, 2);
        exit_ok = 1'b1;
        push(vip_pkg::BTN_CONFIRM, BLANKS);
        exit_ok = 1'b0;
        check_count("exit_o", exit_cnt, 2);

        wait_req();
        en_i = 1'b0; // drop enable mid-capture
        tick(4);

        $display("errors: show %0d, strobe %0d, timeout %0d", show_err, strobe_err, wait_err);
        if (show_err + strobe_err + wait_err == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: rtl/vip_check_top.sv
`timescale 1ns/1ps

module vip_check_top #(
    parameter int AMOUNT_W = 14,
    parameter int DIGITS   = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       en_i,
    input  vip_pkg::btn_t              press_i,
    input  logic [7:0]                 switch_i,
    input  logic [1:0]                 member_i,
    input  logic [vip_pkg::PW_W-1:0]   stored_pw_i,
    input  logic [AMOUNT_W-1:0]        cost_i,
    input  logic [AMOUNT_W-1:0]        save_i,
    input  logic                       entry_done_i,
    input  logic [vip_pkg::PW_W-1:0]   entry_word_i,
    output logic                       entry_req_o,
    output logic [vip_pkg::SHOW_W-1:0] show_o,
    output logic                       wr_o,
    output vip_pkg::wr_kind_t          wr_kind_o,
    output logic [vip_pkg::PW_W-1:0]   new_pw_o,
    output logic                       exit_o
);

    pw_entry_if pw_if ();

    vip_pkg::menu_state_t               state;
    logic [DIGITS*vip_pkg::GLYPH_W-1:0] cost_digits;
    logic [DIGITS*vip_pkg::GLYPH_W-1:0] save_digits;

    vip_menu_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .en_i      (en_i),
        .press_i   (press_i),
        .switch_i  (switch_i),
        .member_i  (member_i),
        .pw        (pw_if.ctrl),
        .state_o   (state),
        .wr_o      (wr_o),
        .wr_kind_o (wr_kind_o),
        .exit_o    (exit_o)
    );

    password_unit u_pw (
        .clk          (clk),
        .rst_n        (rst_n),
        .en_i         (en_i),
        .stored_pw_i  (stored_pw_i),
        .entry_done_i (entry_done_i),
        .entry_word_i (entry_word_i),
        .pw           (pw_if.unit),
        .entry_req_o  (entry_req_o),
        .new_pw_o     (new_pw_o)
    );

    bin_to_bcd #(.AMOUNT_W(AMOUNT_W), .DIGITS(DIGITS)) u_cost_bcd (
        .amount_i (cost_i),
        .digits_o (cost_digits)
    );

    bin_to_bcd #(.AMOUNT_W(AMOUNT_W), .DIGITS(DIGITS)) u_save_bcd (
        .amount_i (save_i),
        .digits_o (save_digits)
    );

    vip_display #(.DIGITS(DIGITS)) u_disp (
        .clk           (clk),
        .rst_n         (rst_n),
        .en_i          (en_i),
        .state_i       (state),
        .cost_digits_i (cost_digits),
        .save_digits_i (save_digits),
        .show_o        (show_o)
    );

endmodule

// File: rtl/vip_display.sv
`timescale 1ns/1ps

module vip_display #(
    parameter int DIGITS = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               en_i,
    input  vip_pkg::menu_state_t               state_i,
    input  logic [DIGITS*vip_pkg::GLYPH_W-1:0] cost_digits_i,
    input  logic [DIGITS*vip_pkg::GLYPH_W-1:0] save_digits_i,
    output logic [vip_pkg::SHOW_W-1:0]         show_o
);

    localparam logic [vip_pkg::GLYPH_W-1:0] GLYPH_FIVE = 5'd5; // stands in for S

    logic [vip_pkg::SHOW_W-1:0] show_d;

    always_comb begin
        case (state_i)
            vip_pkg::ST_LOGIN, vip_pkg::ST_PW_FIRST:
                show_d = {vip_pkg::GLYPH_P, {5{vip_pkg::GLYPH_BLANK}}};
            vip_pkg::ST_PW_SECOND:
                show_d = {vip_pkg::GLYPH_R, vip_pkg::GLYPH_P, {4{vip_pkg::GLYPH_BLANK}}};
            vip_pkg::ST_MENU:
                show_d = {vip_pkg::GLYPH_U, vip_pkg::GLYPH_BLANK, vip_pkg::GLYPH_D,
                          vip_pkg::GLYPH_O, vip_pkg::GLYPH_BLANK, vip_pkg::GLYPH_QUERY};
            vip_pkg::ST_COST:
                show_d = {vip_pkg::GLYPH_C, vip_pkg::GLYPH_O, cost_digits_i};
            vip_pkg::ST_SAVE:
                show_d = {GLYPH_FIVE, vip_pkg::GLYPH_A, save_digits_i};
            vip_pkg::ST_CANCEL_ASK:
                show_d = {vip_pkg::GLYPH_C, vip_pkg::GLYPH_A, vip_pkg::GLYPH_N,
                          vip_pkg::GLYPH_C, vip_pkg::GLYPH_E, vip_pkg::GLYPH_L};
            vip_pkg::ST_NO_VIP:
                show_d = {vip_pkg::GLYPH_N, vip_pkg::GLYPH_O, vip_pkg::GLYPH_BLANK,
                          vip_pkg::GLYPH_V, vip_pkg::GLYPH_I, vip_pkg::GLYPH_P};
            vip_pkg::ST_LOGIN_ERR, vip_pkg::ST_PW_ERR:
                show_d = {vip_pkg::GLYPH_BLANK, vip_pkg::GLYPH_E, vip_pkg::GLYPH_R,
                          vip_pkg::GLYPH_R, vip_pkg::GLYPH_O, vip_pkg::GLYPH_R};
            vip_pkg::ST_PW_DONE, vip_pkg::ST_CANCEL_DONE:
                show_d = {6{vip_pkg::GLYPH_SIX}};
            default:
                show_d = {6{vip_pkg::GLYPH_BLANK}}; // idle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            show_o <= {6{vip_pkg::GLYPH_BLANK}};
        else if (!en_i)
            show_o <= {6{vip_pkg::GLYPH_BLANK}};
        else
            show_o <= show_d;
    end

endmodule

// File: rtl/bin_to_bcd.sv
`timescale 1ns/1ps

module bin_to_bcd #(
    parameter int AMOUNT_W = 14,
    parameter int DIGITS   = 4
) (
    input  logic [AMOUNT_W-1:0]                 amount_i,
    output logic [DIGITS*vip_pkg::GLYPH_W-1:0] digits_o
);

    localparam longint MAX_VAL = 10**DIGITS - 1;

    logic [DIGITS*4-1:0] bcd;
    logic                sat; // amount does not fit the digits

    // double dabble, add 3 before each shift
    always_comb begin
        bcd = '0;
        for (int i = AMOUNT_W - 1; i >= 0; i--) begin
            for (int d = 0; d < DIGITS; d++) begin
                if (bcd[d*4 +: 4] >= 4'd5)
                    bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
            end
            bcd = {bcd[DIGITS*4-2:0], amount_i[i]};
        end
    end

    assign sat = (amount_i > MAX_VAL);

    for (genvar g = 0; g < DIGITS; g++) begin : g_digit
        logic [3:0] nib;
        assign nib = sat ? 4'd9 : bcd[g*4 +: 4];
        assign digits_o[g*vip_pkg::GLYPH_W +: vip_pkg::GLYPH_W] =
            {{(vip_pkg::GLYPH_W-4){1'b0}}, nib};
    end

endmodule

// File: rtl/vip_menu_fsm.sv
`timescale 1ns/1ps

module vip_menu_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en_i,
    input  vip_pkg::btn_t        press_i,
    input  logic [7:0]           switch_i,
    input  logic [1:0]           member_i,
    pw_entry_if.ctrl             pw,
    output vip_pkg::menu_state_t state_o,
    output logic                 wr_o,
    output vip_pkg::wr_kind_t    wr_kind_o,
    output logic                 exit_o
);

    vip_pkg::menu_state_t state_q;
    vip_pkg::menu_state_t state_d;
    vip_pkg::pw_mode_t    mode_d;
    logic                 capturing;
    logic                 accept;
    logic                 exit_d;
    logic                 abort_d;
    logic                 start_d;
    logic                 entered_q; // state changed on the last edge

    assign capturing = (state_q == vip_pkg::ST_LOGIN) || (state_q == vip_pkg::ST_PW_FIRST) ||
                       (state_q == vip_pkg::ST_PW_SECOND);
    assign accept    = (press_i == vip_pkg::BTN_CONFIRM) || (press_i == vip_pkg::BTN_BACK);

    always_comb begin
        state_d = state_q;
        exit_d  = 1'b0;
        abort_d = 1'b0;
        if (state_q == vip_pkg::ST_IDLE) begin
            state_d = (member_i == vip_pkg::MEMBER_ACTIVE) ? vip_pkg::ST_LOGIN
                                                           : vip_pkg::ST_NO_VIP;
        end else if (press_i == vip_pkg::BTN_HOME) begin
            state_d = vip_pkg::ST_IDLE;
            abort_d = capturing;
        end else begin
            case (state_q)
                vip_pkg::ST_LOGIN: begin
                    if (pw.done) begin
                        state_d = pw.ok ? vip_pkg::ST_MENU : vip_pkg::ST_LOGIN_ERR;
                    end else if (press_i == vip_pkg::BTN_BACK) begin
                        state_d = vip_pkg::ST_IDLE;
                        exit_d  = 1'b1;
                        abort_d = 1'b1;
                    end
                end
                vip_pkg::ST_LOGIN_ERR: if (accept) state_d = vip_pkg::ST_LOGIN;
                vip_pkg::ST_NO_VIP, vip_pkg::ST_CANCEL_DONE: begin
                    if (accept) begin
                        state_d = vip_pkg::ST_IDLE;
                        exit_d  = 1'b1;
                    end
                end
                vip_pkg::ST_MENU: begin
                    if (press_i == vip_pkg::BTN_CONFIRM) begin
                        case (switch_i)
                            vip_pkg::MENU_COST:   state_d = vip_pkg::ST_COST;
                            vip_pkg::MENU_SAVE:   state_d = vip_pkg::ST_SAVE;
                            vip_pkg::MENU_PW:     state_d = vip_pkg::ST_PW_FIRST;
                            vip_pkg::MENU_CANCEL: state_d = vip_pkg::ST_CANCEL_ASK;
                            default:              state_d = vip_pkg::ST_MENU;
                        endcase
                    end else if (press_i == vip_pkg::BTN_BACK) begin
                        state_d = vip_pkg::ST_IDLE;
                        exit_d  = 1'b1;
                    end
                end
                vip_pkg::ST_COST, vip_pkg::ST_SAVE, vip_pkg::ST_PW_DONE: begin
                    if (accept) state_d = vip_pkg::ST_MENU;
                end
                vip_pkg::ST_CANCEL_ASK: begin
                    if (press_i == vip_pkg::BTN_CONFIRM) state_d = vip_pkg::ST_CANCEL_DONE;
                    else if (press_i == vip_pkg::BTN_BACK) state_d = vip_pkg::ST_MENU;
                end
                vip_pkg::ST_PW_FIRST: if (pw.done) state_d = vip_pkg::ST_PW_SECOND;
                vip_pkg::ST_PW_SECOND: begin
                    if (pw.done) state_d = pw.ok ? vip_pkg::ST_PW_DONE : vip_pkg::ST_PW_ERR;
                end
                vip_pkg::ST_PW_ERR: if (accept) state_d = vip_pkg::ST_PW_SECOND;
                default: state_d = vip_pkg::ST_IDLE;
            endcase
        end
    end

    // new capture on every entry into a password state
    always_comb begin
        case (state_d)
            vip_pkg::ST_PW_FIRST:  mode_d = vip_pkg::PW_FIRST;
            vip_pkg::ST_PW_SECOND: mode_d = vip_pkg::PW_SECOND;
            default:               mode_d = vip_pkg::PW_LOGIN;
        endcase
        start_d = (state_d != state_q) && ((state_d == vip_pkg::ST_LOGIN) ||
                  (state_d == vip_pkg::ST_PW_FIRST) || (state_d == vip_pkg::ST_PW_SECOND));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= vip_pkg::ST_IDLE;
            entered_q <= 1'b0;
            pw.start  <= 1'b0;
            pw.abort  <= 1'b0;
            wr_o      <= 1'b0;
            exit_o    <= 1'b0;
        end else if (!en_i) begin
            state_q   <= vip_pkg::ST_IDLE;
            entered_q <= 1'b0;
            pw.start  <= 1'b0;
            pw.abort  <= 1'b0;
            wr_o      <= 1'b0;
            exit_o    <= 1'b0;
        end else begin
            state_q   <= state_d;
            entered_q <= (state_d != state_q);
            pw.start  <= start_d;
            pw.abort  <= abort_d;
            wr_o      <= entered_q && ((state_q == vip_pkg::ST_PW_DONE) ||
                                       (state_q == vip_pkg::ST_CANCEL_DONE));
            exit_o    <= exit_d;
        end
    end

    always_ff @(posedge clk) begin
        pw.mode   <= mode_d;
        wr_kind_o <= (state_q == vip_pkg::ST_CANCEL_DONE) ? vip_pkg::WR_CANCEL
                                                          : vip_pkg::WR_UPDATE;
    end

    assign state_o = state_q;

    a_wr_single: assert property (@(posedge clk) disable iff (!rst_n) wr_o |=> !wr_o);
    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state_q <= vip_pkg::ST_PW_DONE);

endmodule

// File: rtl/password_unit.sv
`timescale 1ns/1ps

module password_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en_i,
    input  logic [vip_pkg::PW_W-1:0] stored_pw_i,
    input  logic                     entry_done_i,
    input  logic [vip_pkg::PW_W-1:0] entry_word_i,
    pw_entry_if.unit                 pw,
    output logic                     entry_req_o,
    output logic [vip_pkg::PW_W-1:0] new_pw_o
);

    vip_pkg::pw_mode_t        mode_q;
    logic [vip_pkg::PW_W-1:0] first_pw_q;
    logic                     word_ok;

    always_comb begin
        case (mode_q)
            vip_pkg::PW_LOGIN:  word_ok = (entry_word_i == stored_pw_i);
            vip_pkg::PW_SECOND: word_ok = (entry_word_i == first_pw_q);
            default:            word_ok = 1'b1; // first entry is never wrong
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_req_o <= 1'b0;
            mode_q      <= vip_pkg::PW_LOGIN;
            first_pw_q  <= '0;
            pw.done     <= 1'b0;
            pw.ok       <= 1'b0;
        end else if (!en_i) begin
            entry_req_o <= 1'b0;
            mode_q      <= vip_pkg::PW_LOGIN;
            first_pw_q  <= '0;
            pw.done     <= 1'b0;
            pw.ok       <= 1'b0;
        end else begin
            pw.done <= 1'b0;
            if (pw.abort) begin
                entry_req_o <= 1'b0;
            end else if (entry_req_o && entry_done_i) begin
                entry_req_o <= 1'b0;
                pw.done     <= 1'b1;
                pw.ok       <= word_ok;
                if (mode_q == vip_pkg::PW_FIRST)
                    first_pw_q <= entry_word_i;
            end else if (pw.start) begin
                entry_req_o <= 1'b1; // held until the reader answers
                mode_q      <= pw.mode;
            end
        end
    end

    assign new_pw_o = first_pw_q;

    // keypad must see the request drop right after its answer
    a_req_drops: assert property (@(posedge clk) disable iff (!rst_n)
        entry_done_i |=> !entry_req_o);

endmodule

// File: rtl/pw_entry_if.sv
`timescale 1ns/1ps

// capture request from the menu, result back from the password unit
interface pw_entry_if;

    logic               start;
    logic               abort; // HOME while waiting on the keypad
    vip_pkg::pw_mode_t  mode;
    logic               done;
    logic               ok;    // only meaningful with done

    modport ctrl (
        output start,
        output abort,
        output mode,
        input  done,
        input  ok
    );

    modport unit (
        input  start,
        input  abort,
        input  mode,
        output done,
        output ok
    );

endinterface

// File: rtl/vip_pkg.sv
package vip_pkg;

    localparam int PW_DIGITS = 4;
    localparam int GLYPH_W   = 5;
    localparam int PW_W      = PW_DIGITS * GLYPH_W; // four key codes
    localparam int SHOW_W    = 6 * GLYPH_W;

    // display characters, 0..9 are plain digits
    localparam logic [GLYPH_W-1:0] GLYPH_A     = 5'd10;
    localparam logic [GLYPH_W-1:0] GLYPH_C     = 5'd12;
    localparam logic [GLYPH_W-1:0] GLYPH_D     = 5'd13;
    localparam logic [GLYPH_W-1:0] GLYPH_E     = 5'd14;
    localparam logic [GLYPH_W-1:0] GLYPH_F     = 5'd15;
    localparam logic [GLYPH_W-1:0] GLYPH_I     = 5'd17;
    localparam logic [GLYPH_W-1:0] GLYPH_L     = 5'd19;
    localparam logic [GLYPH_W-1:0] GLYPH_N     = 5'd20;
    localparam logic [GLYPH_W-1:0] GLYPH_O     = 5'd21;
    localparam logic [GLYPH_W-1:0] GLYPH_P     = 5'd22;
    localparam logic [GLYPH_W-1:0] GLYPH_R     = 5'd24;
    localparam logic [GLYPH_W-1:0] GLYPH_U     = 5'd26;
    localparam logic [GLYPH_W-1:0] GLYPH_V     = 5'd27;
    localparam logic [GLYPH_W-1:0] GLYPH_QUERY = 5'd29;
    localparam logic [GLYPH_W-1:0] GLYPH_BLANK = 5'd31;
    localparam logic [GLYPH_W-1:0] GLYPH_SIX   = 5'd6;

    typedef enum logic [2:0] {
        BTN_NEXT    = 3'd0,
        BTN_BACK    = 3'd1,
        BTN_CONFIRM = 3'd2,
        BTN_DELETE  = 3'd3,
        BTN_HOME    = 3'd4,
        BTN_NONE    = 3'd7
    } btn_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_LOGIN, ST_LOGIN_ERR, ST_NO_VIP, ST_MENU, ST_COST, ST_SAVE,
        ST_CANCEL_ASK, ST_CANCEL_DONE, ST_PW_FIRST, ST_PW_SECOND, ST_PW_ERR, ST_PW_DONE
    } menu_state_t;

    typedef enum logic [1:0] {PW_LOGIN, PW_FIRST, PW_SECOND} pw_mode_t;

    typedef enum logic [0:0] {WR_UPDATE, WR_CANCEL} wr_kind_t;

    localparam logic [1:0] MEMBER_ACTIVE = 2'b11;

    // switch bits as wired on the kiosk panel
    localparam logic [7:0] MENU_CANCEL = 8'd1;
    localparam logic [7:0] MENU_COST   = 8'd2;
    localparam logic [7:0] MENU_SAVE   = 8'd4;
    localparam logic [7:0] MENU_PW     = 8'd8;

endpackage
